// File: rtl/exec_pkg.sv
// Execution cluster shared types
package exec_pkg;

    localparam int DATA_W = 32;  // Operand and result width.
    localparam int IMM_W  = 16;  // Instruction immediate width.

    typedef logic [DATA_W-1:0] data_t;

    // Opcodes of the simple-ALU lane, including the multiply/divide group.
    typedef enum logic [7:0] {
        NOP,
        ADD, ADDI, ADDU, ADDIU,
        SUB, SUBU,
        MFHI, MTHI, MFLO, MTLO,
        AND_, ANDI,
        OR, ORI,
        XOR, XORI,
        NOR,
        SLL, SLLV,
        SRL, SRLV,
        SRA, SRAV,
        SLT, SLTI,
        SLTU, SLTIU,
        LUI,
        MULT, MULTU,
        DIV, DIVU
    } opcode_e;

    // Execution flags reported with every completed operation.
    typedef struct packed {
        logic ctrl_op;     // Control transfer, unused in this lane.
        logic dest_valid;  // Result carries a register value.
        logic branch;      // Branch operation, unused in this lane.
        logic executed;    // Operation has completed.
        logic exception;   // Signed overflow or divide by zero.
        logic mispredict;  // Branch mispredict, unused in this lane.
    } exec_flags_t;

    typedef enum logic [1:0] {
        MD_MULT,
        MD_MULTU,
        MD_DIV,
        MD_DIVU
    } md_kind_e;

endpackage

// File: rtl/muldiv_if.sv
// Multiply/divide control bus
interface muldiv_if import exec_pkg::*; ();

    logic     start;     // One-cycle pulse that loads operands and the counter.
    md_kind_e kind;      // Operation selected for this run.
    data_t    op_a;      // Multiplicand or dividend.
    data_t    op_b;      // Multiplier or divisor.
    logic     step;      // High for each iteration cycle.
    logic     last;      // High during the final iteration step.
    data_t    hi_res;    // Result for HI, valid with last.
    data_t    lo_res;    // Result for LO, valid with last.
    logic     div_zero;  // Divisor of the current run is zero.

    modport ctrl (output start, kind, op_a, op_b, step, input last);
    modport cnt  (input start, step, output last);
    modport dp   (input start, kind, op_a, op_b, step, output hi_res, lo_res, div_zero);

endinterface

// File: rtl/simple_alu.sv
// Single-cycle integer ALU
module simple_alu import exec_pkg::*; (
    input  data_t            data1_i,
    input  data_t            data2_i,
    input  logic [IMM_W-1:0] immd_i,
    input  opcode_e          opcode_i,
    output data_t            result_o,
    output exec_flags_t      flags_o
);

    data_t sext_imm;
    data_t zext_imm;
    data_t add_b;
    data_t sum;
    data_t diff;
    logic  add_ovf;
    logic  sub_ovf;
    data_t result;
    logic  dest_valid;
    logic  exception;

    assign sext_imm = {{(DATA_W-IMM_W){immd_i[IMM_W-1]}}, immd_i};
    assign zext_imm = {{(DATA_W-IMM_W){1'b0}}, immd_i};

    // One adder serves both register and immediate forms.
    assign add_b = (opcode_i inside {ADDI, ADDIU}) ? sext_imm : data2_i;
    assign sum   = data1_i + add_b;
    assign diff  = data1_i - data2_i;

    // Overflow when the operands agree in sign and the result does not.
    assign add_ovf = (data1_i[DATA_W-1] == add_b[DATA_W-1]) &&
                     (sum[DATA_W-1] != data1_i[DATA_W-1]);
    assign sub_ovf = (data1_i[DATA_W-1] != data2_i[DATA_W-1]) &&
                     (diff[DATA_W-1] != data1_i[DATA_W-1]);

    always_comb begin
        result     = '0;
        dest_valid = 1'b1;
        exception  = 1'b0;
        case (opcode_i)
            ADD, ADDI: begin
                result    = sum;
                exception = add_ovf;
            end
            ADDU, ADDIU: result = sum;
            SUB: begin
                result    = diff;
                exception = sub_ovf;
            end
            SUBU: result = diff;
            MFHI, MTHI, MFLO, MTLO: result = data1_i;  // HI/LO value is muxed onto data1.
            AND_:  result = data1_i & data2_i;
            ANDI:  result = data1_i & zext_imm;
            OR:    result = data1_i | data2_i;
            ORI:   result = data1_i | zext_imm;
            XOR:   result = data1_i ^ data2_i;
            XORI:  result = data1_i ^ zext_imm;
            NOR:   result = ~(data1_i | data2_i);
            SLL:   result = data1_i << immd_i[4:0];
            SLLV:  result = data2_i << data1_i[4:0];
            SRL:   result = data1_i >> immd_i[4:0];
            SRLV:  result = data2_i >> data1_i[4:0];
            SRA:   result = $signed(data1_i) >>> immd_i[4:0];
            SRAV:  result = $signed(data2_i) >>> data1_i[4:0];
            SLT:   result = data_t'($signed(data1_i) < $signed(data2_i));
            SLTI:  result = data_t'($signed(data1_i) < $signed(sext_imm));
            SLTU:  result = data_t'(data1_i < data2_i);
            SLTIU: result = data_t'(data1_i < sext_imm);  // Sign-extended, compared unsigned.
            LUI:   result = {immd_i, {(DATA_W-IMM_W){1'b0}}};
            default: begin
                dest_valid = 1'b0;  // NOP and the multiply/divide group return nothing here.
            end
        endcase
    end

    assign result_o = result;

    always_comb begin
        flags_o            = '0;
        flags_o.dest_valid = dest_valid;
        flags_o.executed   = 1'b1;
        flags_o.exception  = exception;
    end

endmodule

// File: rtl/muldiv_datapath.sv
// Iterative multiply/divide datapath
module muldiv_datapath import exec_pkg::*; (
    input logic  clk_i,
    input logic  arst_n_i,
    muldiv_if.dp md
);

    logic [2*DATA_W-1:0] acc;          // Product, or remainder over quotient.
    logic [2*DATA_W-1:0] acc_nxt;
    logic [2*DATA_W-1:0] prod_fix;
    logic [DATA_W:0]     mul_sum;
    logic [DATA_W+1:0]   div_diff;
    data_t               b_mag;        // Multiplicand or divisor magnitude.
    data_t               dividend;
    data_t               a_mag_in;
    data_t               b_mag_in;
    data_t               quot;
    data_t               rem;
    logic                kind_signed;
    logic                kind_div;
    logic                is_div;
    logic                neg_lo;       // Product or quotient is negated at the end.
    logic                neg_hi;       // Remainder is negated at the end.
    logic                div_zero_q;

    assign kind_signed = md.kind inside {MD_MULT, MD_DIV};
    assign kind_div    = md.kind inside {MD_DIV, MD_DIVU};
    assign a_mag_in    = (kind_signed && md.op_a[DATA_W-1]) ? -md.op_a : md.op_a;
    assign b_mag_in    = (kind_signed && md.op_b[DATA_W-1]) ? -md.op_b : md.op_b;

    // One iteration: shift-add for multiply, restoring subtract for divide.
    assign mul_sum  = {1'b0, acc[2*DATA_W-1:DATA_W]} + {1'b0, b_mag};
    assign div_diff = {1'b0, acc[2*DATA_W-1:DATA_W-1]} - {2'b00, b_mag};

    always_comb begin
        if (is_div) begin
            if (div_diff[DATA_W+1]) begin
                acc_nxt = {acc[2*DATA_W-2:0], 1'b0};  // Partial remainder too small, restore.
            end else begin
                acc_nxt = {div_diff[DATA_W-1:0], acc[DATA_W-2:0], 1'b1};
            end
        end else if (acc[0]) begin
            acc_nxt = {mul_sum, acc[DATA_W-1:1]};
        end else begin
            acc_nxt = {1'b0, acc[2*DATA_W-1:1]};
        end
    end

    // Sign fix-up of the final step, sampled by HI/LO when last is high.
    assign prod_fix = neg_lo ? -acc_nxt : acc_nxt;
    assign quot     = neg_lo ? -acc_nxt[DATA_W-1:0] : acc_nxt[DATA_W-1:0];
    assign rem      = neg_hi ? -acc_nxt[2*DATA_W-1:DATA_W] : acc_nxt[2*DATA_W-1:DATA_W];

    always_comb begin
        if (!is_div) begin
            md.hi_res = prod_fix[2*DATA_W-1:DATA_W];
            md.lo_res = prod_fix[DATA_W-1:0];
        end else if (div_zero_q) begin
            md.hi_res = dividend;
            md.lo_res = '1;
        end else begin
            md.hi_res = rem;
            md.lo_res = quot;
        end
    end

    assign md.div_zero = div_zero_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            is_div     <= 1'b0;
            neg_lo     <= 1'b0;
            neg_hi     <= 1'b0;
            div_zero_q <= 1'b0;
        end else if (md.start) begin
            is_div     <= kind_div;
            neg_lo     <= kind_signed && (md.op_a[DATA_W-1] ^ md.op_b[DATA_W-1]);
            neg_hi     <= kind_signed && kind_div && md.op_a[DATA_W-1];  // Dividend's sign.
            div_zero_q <= kind_div && (md.op_b == '0);
        end
    end

    always_ff @(posedge clk_i) begin
        if (md.start) begin
            acc      <= {{DATA_W{1'b0}}, a_mag_in};
            b_mag    <= b_mag_in;
            dividend <= md.op_a;
        end else if (md.step) begin
            acc <= acc_nxt;
        end
    end

endmodule

// File: rtl/step_counter.sv
// Iteration step counter
module step_counter (
    input logic   clk_i,
    input logic   arst_n_i,
    muldiv_if.cnt md
);

    logic [4:0] count;  // Steps left after the current one.

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count <= '0;
        end else if (md.start) begin
            count <= 5'd31;
        end else if (md.step) begin
            count <= count - 5'd1;
        end
    end

    assign md.last = md.step && (count == '0);

endmodule

// File: rtl/exec_ctrl_fsm.sv
// Issue and sequencing control
module exec_ctrl_fsm import exec_pkg::*; (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    issue_valid_i,
    input  opcode_e opcode_i,
    input  data_t   data1_i,
    input  data_t   data2_i,
    muldiv_if.ctrl  md,
    output logic    use_hi_o,
    output logic    use_lo_o,
    output logic    hi_we_o,
    output logic    lo_we_o,
    output logic    alu_done_o,
    output logic    md_done_o,
    output logic    busy_o
);

    typedef enum logic [1:0] {IDLE, START, RUN, DONE} state_e;

    state_e   state;
    state_e   state_nxt;
    logic     accept;
    logic     is_md;
    md_kind_e kind_q;
    data_t    op_a_q;
    data_t    op_b_q;

    assign is_md  = opcode_i inside {MULT, MULTU, DIV, DIVU};
    assign accept = issue_valid_i && (state == IDLE);  // Issues outside IDLE are dropped.

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept && is_md) begin
                    state_nxt = START;
                end
            end
            START: state_nxt = RUN;
            RUN: begin
                if (md.last) begin
                    state_nxt = DONE;
                end
            end
            DONE: state_nxt = IDLE;  // One dead cycle before the next issue.
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && is_md) begin
            op_a_q <= data1_i;
            op_b_q <= data2_i;
            case (opcode_i)
                MULTU:   kind_q <= MD_MULTU;
                DIV:     kind_q <= MD_DIV;
                DIVU:    kind_q <= MD_DIVU;
                default: kind_q <= MD_MULT;
            endcase
        end
    end

    assign md.start = (state == START);
    assign md.step  = (state == RUN);
    assign md.kind  = kind_q;
    assign md.op_a  = op_a_q;
    assign md.op_b  = op_b_q;

    assign use_hi_o   = (opcode_i == MFHI);
    assign use_lo_o   = (opcode_i == MFLO);
    assign hi_we_o    = accept && (opcode_i == MTHI);
    assign lo_we_o    = accept && (opcode_i == MTLO);
    assign alu_done_o = accept && !is_md;
    assign md_done_o  = (state == RUN) && md.last;  // HI/LO and writeback take the final step.
    assign busy_o     = (state == START) || (state == RUN);

endmodule

// File: rtl/hilo_regs.sv
// HI and LO registers
module hilo_regs import exec_pkg::*; (
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  hi_we_i,
    input  logic  lo_we_i,
    input  data_t wdata_i,
    input  logic  md_done_i,
    input  data_t md_hi_i,
    input  data_t md_lo_i,
    output data_t hi_o,
    output data_t lo_o
);

    data_t hi_q;
    data_t lo_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (md_done_i) begin
            hi_q <= md_hi_i;  // Completion writes the pair together.
            lo_q <= md_lo_i;
        end else begin
            if (hi_we_i) begin
                hi_q <= wdata_i;
            end
            if (lo_we_i) begin
                lo_q <= wdata_i;
            end
        end
    end

    assign hi_o = hi_q;
    assign lo_o = lo_q;

endmodule

// File: rtl/exec_writeback.sv
// Result writeback register
module exec_writeback import exec_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        alu_done_i,
    input  data_t       alu_result_i,
    input  exec_flags_t alu_flags_i,
    input  logic        md_done_i,
    input  logic        md_div_zero_i,
    output logic        result_valid_o,
    output data_t       result_o,
    output exec_flags_t flags_o
);

    exec_flags_t md_flags;

    // Multiply/divide completion writes HI/LO only, so no register value.
    always_comb begin
        md_flags           = '0;
        md_flags.executed  = 1'b1;
        md_flags.exception = md_div_zero_i;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= alu_done_i || md_done_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (md_done_i) begin
            result_o <= '0;
            flags_o  <= md_flags;
        end else if (alu_done_i) begin
            result_o <= alu_result_i;
            flags_o  <= alu_flags_i;
        end
    end

endmodule

// File: rtl/exec_unit_top.sv
// Integer execution cluster
module exec_unit_top import exec_pkg::*; (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             issue_valid_i,
    input  opcode_e          opcode_i,
    input  data_t            data1_i,
    input  data_t            data2_i,
    input  logic [IMM_W-1:0] immd_i,
    output logic             result_valid_o,
    output data_t            result_o,
    output exec_flags_t      flags_o,
    output logic             busy_o
);

    logic        use_hi;
    logic        use_lo;
    logic        hi_we;
    logic        lo_we;
    logic        alu_done;
    logic        md_done;
    data_t       hi_q;
    data_t       lo_q;
    data_t       alu_data1;
    data_t       alu_result;
    exec_flags_t alu_flags;

    muldiv_if md_bus ();

    exec_ctrl_fsm u_ctrl (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .issue_valid_i (issue_valid_i),
        .opcode_i      (opcode_i),
        .data1_i       (data1_i),
        .data2_i       (data2_i),
        .md            (md_bus.ctrl),
        .use_hi_o      (use_hi),
        .use_lo_o      (use_lo),
        .hi_we_o       (hi_we),
        .lo_we_o       (lo_we),
        .alu_done_o    (alu_done),
        .md_done_o     (md_done),
        .busy_o        (busy_o)
    );

    step_counter u_step_cnt (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .md       (md_bus.cnt)
    );

    muldiv_datapath u_muldiv (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .md       (md_bus.dp)
    );

    hilo_regs u_hilo (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .hi_we_i   (hi_we),
        .lo_we_i   (lo_we),
        .wdata_i   (data1_i),
        .md_done_i (md_done),
        .md_hi_i   (md_bus.hi_res),
        .md_lo_i   (md_bus.lo_res),
        .hi_o      (hi_q),
        .lo_o      (lo_q)
    );

    // MFHI and MFLO read the pair through the first ALU operand.
    assign alu_data1 = use_hi ? hi_q : (use_lo ? lo_q : data1_i);

    simple_alu u_alu (
        .data1_i  (alu_data1),
        .data2_i  (data2_i),
        .immd_i   (immd_i),
        .opcode_i (opcode_i),
        .result_o (alu_result),
        .flags_o  (alu_flags)
    );

    exec_writeback u_wb (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .alu_done_i     (alu_done),
        .alu_result_i   (alu_result),
        .alu_flags_i    (alu_flags),
        .md_done_i      (md_done),
        .md_div_zero_i  (md_bus.div_zero),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .flags_o        (flags_o)
    );

endmodule

// File: tests/exec_ref.svh
// Reference model for the execution cluster
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// Next state of the stimulus generator.
function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// True when a wide sum no longer fits a signed 32-bit register.
function automatic bit overflows_int32(input longint value);
    return (value > 64'sd2147483647) || (value < -64'sd2147483648);
endfunction

function automatic data_t alu_ref_result(input opcode_e op, input data_t d1, input data_t d2,
                                         input logic [15:0] imm, input data_t hi,
                                         input data_t lo);
    data_t      sx;
    data_t      zx;
    data_t      res;
    logic [4:0] sh;
    sx  = {{16{imm[15]}}, imm};  // Arithmetic and compare immediates.
    zx  = {16'h0000, imm};       // Logic immediates.
    sh  = imm[4:0];
    res = '0;
    case (op)
        ADD, ADDU:   res = d1 + d2;
        ADDI, ADDIU: res = d1 + sx;
        SUB, SUBU:   res = d1 - d2;
        MFHI:        res = hi;
        MFLO:        res = lo;
        MTHI, MTLO:  res = d1;  // The moved value is reported.
        AND_:        res = d1 & d2;
        ANDI:        res = d1 & zx;
        OR:          res = d1 | d2;
        ORI:         res = d1 | zx;
        XOR:         res = d1 ^ d2;
        XORI:        res = d1 ^ zx;
        NOR:         res = ~(d1 | d2);
        SLL:         res = d1 << sh;
        SLLV:        res = d2 << d1[4:0];
        SRL:         res = d1 >> sh;
        SRLV:        res = d2 >> d1[4:0];
        SRA:         res = (d1 >> sh) | (d1[31] ? ~(32'hffffffff >> sh) : 32'h0);
        SRAV:        res = (d2 >> d1[4:0]) | (d2[31] ? ~(32'hffffffff >> d1[4:0]) : 32'h0);
        SLT:         res = {31'b0, (longint'($signed(d1)) < longint'($signed(d2)))};
        SLTI:        res = {31'b0, (longint'($signed(d1)) < longint'($signed(sx)))};
        SLTU:        res = {31'b0, (d1 < d2)};
        SLTIU:       res = {31'b0, (d1 < sx)};
        LUI:         res = {imm, 16'h0000};
        default:     res = '0;
    endcase
    return res;
endfunction

function automatic exec_flags_t alu_ref_flags(input opcode_e op, input data_t d1,
                                              input data_t d2, input logic [15:0] imm);
    exec_flags_t f;
    data_t       sx;
    sx           = {{16{imm[15]}}, imm};
    f            = '0;
    f.executed   = 1'b1;
    f.dest_valid = (op != NOP);
    case (op)
        ADD:     f.exception = overflows_int32(longint'($signed(d1)) + longint'($signed(d2)));
        ADDI:    f.exception = overflows_int32(longint'($signed(d1)) + longint'($signed(sx)));
        SUB:     f.exception = overflows_int32(longint'($signed(d1)) - longint'($signed(d2)));
        default: f.exception = 1'b0;
    endcase
    return f;
endfunction

function automatic void md_ref(input opcode_e op, input data_t a, input data_t b,
                               output data_t hi, output data_t lo, output logic dz);
    logic [63:0] p;
    longint      q;
    longint      r;
    p  = '0;
    dz = 1'b0;
    case (op)
        MULT:  p = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // Low 64 bits of the signed product.
        MULTU: p = {32'h0, a} * {32'h0, b};
        DIV: begin
            if (b != '0) begin
                q = longint'($signed(a)) / longint'($signed(b));  // Wide, so MIN / -1 is safe.
                r = longint'($signed(a)) % longint'($signed(b));
                p = {data_t'(r), data_t'(q)};
            end
        end
        DIVU: begin
            if (b != '0) begin
                p = {a % b, a / b};
            end
        end
        default: p = '0;
    endcase
    hi = p[63:32];
    lo = p[31:0];
    if ((op inside {DIV, DIVU}) && (b == '0)) begin
        dz = 1'b1;
        hi = a;
        lo = '1;
    end
endfunction

function automatic exec_flags_t md_ref_flags(input logic dz);
    exec_flags_t f;
    f           = '0;
    f.executed  = 1'b1;
    f.exception = dz;
    return f;
endfunction

`endif

// File: tests/tb_exec_unit.sv
// Execution cluster testbench
module tb_exec_unit import exec_pkg::*; ;

    localparam int PERIOD       = 4;
    localparam int RESET_CYCLES = 5;
    localparam int ALU_LAT      = 1;   // Cycles from the driving edge to the result.
    localparam int MD_LAT       = 34;
    localparam int MD_BUSY      = 33;  // Cycles busy_o stays high for one multiply/divide.
    localparam int N_ARITH      = 20;
    localparam int N_LOGIC      = 10;
    localparam int N_SHIFT      = 10;
    localparam int N_MD         = 6;
    localparam int TOTAL_OPS    = 3 + 64 + 16 + N_ARITH * 6 + N_LOGIC * 8 + N_SHIFT * 10 +
                                  N_MD * 12 + 3 + 3 + 10 + 2;
    localparam int CYCLE_LIMIT  = TOTAL_OPS * 40 + 100;

    `include "exec_ref.svh"

    logic             clk;
    logic             arst_n;
    logic             issue_valid;
    opcode_e          opcode;
    data_t            data1;
    data_t            data2;
    logic [IMM_W-1:0] immd;
    logic             result_valid;
    data_t            result;
    exec_flags_t      flags;
    logic             busy;

    data_t       model_hi;      // HI as the reference sees it.
    data_t       model_lo;
    logic [31:0] rng_state;
    int          cycle_cnt;
    data_t       exp_data_q [$];
    exec_flags_t exp_flags_q [$];
    time         exp_time_q [$];
    int          exp_lat_q [$];

    opcode_e arith_ops [6]  = '{ADD, ADDU, ADDI, ADDIU, SUB, SUBU};
    opcode_e logic_ops [8]  = '{AND_, ANDI, OR, ORI, XOR, XORI, NOR, LUI};
    opcode_e shift_ops [10] = '{SLL, SLLV, SRL, SRLV, SRA, SRAV, SLT, SLTI, SLTU, SLTIU};
    opcode_e md_ops [4]     = '{MULT, MULTU, DIV, DIVU};
    data_t   edge_vals [4]  = '{32'h7fffffff, 32'h80000000, 32'hffffffff, 32'h00000001};

    exec_unit_top uut (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .issue_valid_i  (issue_valid),
        .opcode_i       (opcode),
        .data1_i        (data1),
        .data2_i        (data2),
        .immd_i         (immd),
        .result_valid_o (result_valid),
        .result_o       (result),
        .flags_o        (flags),
        .busy_o         (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at time %0t: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_flags(input exec_flags_t got, input exec_flags_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at time %0t: flags_o got %b expected %b",
                                $time, got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at time %0t: %s got %b expected %b",
                                $time, name, got, exp));
        end
    endtask

    function automatic data_t next_rand();
        rng_state = lcg_step(rng_state);
        return rng_state;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n   <= 1'b1;
        model_hi = '0;  // HI and LO clear with the DUT.
        model_lo = '0;
        @(negedge clk);
        check_level("result_valid_o", result_valid, 1'b0);
        check_level("busy_o", busy, 1'b0);
    endtask

    // One falling edge later, busy_o must be high only while a multiply/divide runs.
    task automatic sample_busy(inout int cycles, input bit md_op);
        @(negedge clk);
        cycles = cycles + 1;
        check_level("busy_o", busy, md_op && (cycles <= MD_BUSY));
    endtask

    // Issue one operation, then wait until its result is checked and the unit is free.
    task automatic run_op(input opcode_e op, input data_t d1, input data_t d2,
                          input logic [IMM_W-1:0] imm, input bit drop_next);
        data_t       exp_data;
        exec_flags_t exp_flags;
        data_t       md_hi;
        data_t       md_lo;
        logic        dz;
        int          lat;
        int          cycles;
        if (op inside {MULT, MULTU, DIV, DIVU}) begin
            md_ref(op, d1, d2, md_hi, md_lo, dz);
            model_hi  = md_hi;
            model_lo  = md_lo;
            exp_data  = '0;
            exp_flags = md_ref_flags(dz);
            lat       = MD_LAT;
        end else begin
            exp_data  = alu_ref_result(op, d1, d2, imm, model_hi, model_lo);
            exp_flags = alu_ref_flags(op, d1, d2, imm);
            lat       = ALU_LAT;
            if (op == MTHI) model_hi = d1;
            if (op == MTLO) model_lo = d1;
        end
        cycles = 0;
        @(posedge clk);
        issue_valid <= 1'b1;
        opcode      <= op;
        data1       <= d1;
        data2       <= d2;
        immd        <= imm;
        exp_data_q.push_back(exp_data);
        exp_flags_q.push_back(exp_flags);
        exp_time_q.push_back($time);
        exp_lat_q.push_back(lat);
        @(posedge clk);
        if (drop_next) begin
            opcode <= ADD;  // Lands while busy, so no result may appear for it.
            sample_busy(cycles, lat == MD_LAT);
            @(posedge clk);
        end
        issue_valid <= 1'b0;
        while (exp_data_q.size() != 0 || busy) sample_busy(cycles, lat == MD_LAT);
    endtask

    // Compare process, sampling on the falling edge where outputs are settled.
    always @(negedge clk) begin
        data_t       exp_data;
        exec_flags_t exp_flags;
        time         t_issue;
        int          exp_lat;
        int          lat;
        if (arst_n && result_valid) begin
            if (exp_data_q.size() == 0) begin
                abort_run("result_valid_o was asserted with no operation outstanding");
            end else begin
                exp_data  = exp_data_q.pop_front();
                exp_flags = exp_flags_q.pop_front();
                t_issue   = exp_time_q.pop_front();
                exp_lat   = exp_lat_q.pop_front();
                check_data("result_o", result, exp_data);
                check_flags(flags, exp_flags);
                lat = int'(($time - t_issue) / PERIOD);
                if (lat != exp_lat) begin
                    abort_run($sformatf("result arrived %0d cycles after issue, expected %0d",
                                        lat, exp_lat));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout after %0d cycles with %0d results never delivered",
                                cycle_cnt, exp_data_q.size()));
        end
    end

    initial begin
        data_t            a;
        data_t            b;
        data_t            r;
        logic [IMM_W-1:0] imm;
        arst_n      = 1'b0;
        issue_valid = 1'b0;
        opcode      = NOP;
        data1       = '0;
        data2       = '0;
        immd        = '0;
        model_hi    = '0;
        model_lo    = '0;
        rng_state   = 32'h35c2b185;
        cycle_cnt   = 0;
        apply_reset();

        run_op(MFHI, 32'h12345678, '0, '0, 1'b0);  // HI and LO start at zero.
        run_op(MFLO, 32'h9abcdef0, '0, '0, 1'b0);
        run_op(NOP, 32'hdeadbeef, 32'h1, 16'hffff, 1'b0);

        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                run_op(ADD, edge_vals[i], edge_vals[j], '0, 1'b0);
                run_op(ADDU, edge_vals[i], edge_vals[j], '0, 1'b0);
                run_op(SUB, edge_vals[i], edge_vals[j], '0, 1'b0);
                run_op(SUBU, edge_vals[i], edge_vals[j], '0, 1'b0);
            end
            run_op(ADDI, edge_vals[i], '0, 16'h7fff, 1'b0);
            run_op(ADDI, edge_vals[i], '0, 16'h8000, 1'b0);
            run_op(ADDIU, edge_vals[i], '0, 16'h7fff, 1'b0);
            run_op(ADDIU, edge_vals[i], '0, 16'h8000, 1'b0);
        end
        for (int i = 0; i < N_ARITH; i++) begin
            a   = next_rand();
            b   = next_rand();
            r   = next_rand();
            imm = r[15:0];
            foreach (arith_ops[k]) run_op(arith_ops[k], a, b, imm, 1'b0);
        end

        for (int i = 0; i < N_LOGIC; i++) begin
            a   = next_rand();
            b   = next_rand();
            r   = next_rand();
            imm = r[15:0] | 16'h8000;  // Negative immediates expose the extension rule.
            foreach (logic_ops[k]) run_op(logic_ops[k], a, b, imm, 1'b0);
        end

        for (int i = 0; i < N_SHIFT; i++) begin
            a   = next_rand();
            b   = next_rand();
            r   = next_rand();
            imm = r[15:0];
            if (i[0]) begin
                a = a & 32'h7fffffff;
                b = b | 32'h80000000;
            end else begin
                a = a | 32'h80000000;
                b = b & 32'h7fffffff;
            end
            foreach (shift_ops[k]) run_op(shift_ops[k], a, b, imm, 1'b0);
        end

        for (int i = 0; i < N_MD; i++) begin
            a = next_rand();
            b = next_rand();
            if (i[0]) b = b >> 20;  // Small divisors give large quotients.
            foreach (md_ops[k]) begin
                run_op(md_ops[k], a, b, '0, 1'b0);
                run_op(MFHI, '0, '0, '0, 1'b0);
                run_op(MFLO, '0, '0, '0, 1'b0);
            end
        end
        run_op(DIV, 32'h80000000, 32'hffffffff, '0, 1'b0);
        run_op(MFHI, '0, '0, '0, 1'b0);
        run_op(MFLO, '0, '0, '0, 1'b0);
        run_op(MULT, 32'hfffffffd, 32'h00000007, '0, 1'b1);  // Second issue is dropped.
        run_op(MFHI, '0, '0, '0, 1'b0);
        run_op(MFLO, '0, '0, '0, 1'b0);

        run_op(MTHI, 32'hcafef00d, '0, '0, 1'b0);
        run_op(MTLO, 32'h0badc0de, '0, '0, 1'b0);
        run_op(MFHI, '0, '0, '0, 1'b0);
        run_op(MFLO, '0, '0, '0, 1'b0);
        run_op(DIV, 32'hfedcba98, '0, '0, 1'b0);
        run_op(MFHI, '0, '0, '0, 1'b0);
        run_op(MFLO, '0, '0, '0, 1'b0);
        run_op(DIVU, 32'h76543210, '0, '0, 1'b0);
        run_op(MFHI, '0, '0, '0, 1'b0);
        run_op(MFLO, '0, '0, '0, 1'b0);

        apply_reset();
        run_op(MFHI, '0, '0, '0, 1'b0);
        run_op(MFLO, '0, '0, '0, 1'b0);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+tests
rtl/exec_pkg.sv
rtl/muldiv_if.sv
rtl/simple_alu.sv
rtl/muldiv_datapath.sv
rtl/step_counter.sv
rtl/exec_ctrl_fsm.sv
rtl/hilo_regs.sv
rtl/exec_writeback.sv
rtl/exec_unit_top.sv
tests/tb_exec_unit.sv

// File: Makefile
# Verilator flow for the execution cluster testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_unit
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= run.log
VFLAGS    ?= --binary -j 0

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "Simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
